// ==== src/video_config.svh ====
//--------------------------------------------------------------------
// Video subsystem configuration
// Screen geometry, table sizes and pixel pipeline latency
//--------------------------------------------------------------------
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Raster geometry, in 6 MHz pixels and lines
`define VID_H_TOTAL      384
`define VID_H_VISIBLE    256
`define VID_V_TOTAL      264
`define VID_V_FIRST      16    // First visible line
`define VID_V_LAST       239   // Last visible line

// Tables
`define VID_MAP_COLS     32
`define VID_OBJ_COUNT    16
`define VID_OBJ_PER_LINE 4     // Line buffer draw limit

// Pixel strobes from counter value to registered RGB
`define VID_PIX_LATENCY  2

`endif

// ==== src/video_pkg.sv ====
//--------------------------------------------------------------------
// Video package
// Shared widths, object scan states and the character pixel rule
//--------------------------------------------------------------------
`default_nettype none

package video_pkg;

   typedef logic [8:0] h_cnt_t;     // Horizontal pixel count
   typedef logic [8:0] v_cnt_t;     // Line count
   typedef logic [1:0] pix_t;       // 0 is transparent
   typedef logic [3:0] colour_t;    // Colour group
   typedef logic [6:0] pal_index_t; // {obj, colour, pix}
   typedef logic [7:0] rgb_t;       // 3-3-2

   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_COMPARE,
      SCAN_DRAW
   } scan_state_t;

   // Stand-in for the graphics ROMs, shared by tiles and sprites.
   // The field of the code picked by (column xor row) mod 4 is the pixel.
   function automatic pix_t char_pix(input logic [7:0] code,
                                     input logic [1:0] col,
                                     input logic [1:0] row);
      logic [1:0] field;
      field = col ^ row;
      return code[{field, 1'b0} +: 2];
   endfunction

endpackage

`default_nettype wire

// ==== src/video_timing.sv ====
//--------------------------------------------------------------------
// Video timing generator
// Pixel and line counters stepped on the 6 MHz strobe, with blank,
// hblank start and VRAM busy decoded from the counts
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module video_timing (
   input  wire logic          clk_48m,
   input  wire logic          reset,
   input  wire logic          cen_6m,
   output video_pkg::h_cnt_t  h_cnt,
   output video_pkg::v_cnt_t  v_cnt,
   output logic               blank,
   output logic               hblank_start,
   output logic               vram_busy_n
);

   logic vis_line;

   always_ff @(posedge clk_48m) begin
      if (reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (cen_6m) begin
         if (h_cnt == 9'(`VID_H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == 9'(`VID_V_TOTAL - 1))
               v_cnt <= '0;
            else
               v_cnt <= v_cnt + 1'b1;
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   assign vis_line     = (v_cnt >= 9'(`VID_V_FIRST)) && (v_cnt <= 9'(`VID_V_LAST));
   assign blank        = !(vis_line && (h_cnt < 9'(`VID_H_VISIBLE)));
   assign hblank_start = (h_cnt == 9'(`VID_H_VISIBLE)); // Held for one strobe period
   assign vram_busy_n  = !vis_line;                     // Whole line, hblank included

endmodule

`default_nettype wire

// ==== src/tile_vram.sv ====
//--------------------------------------------------------------------
// Background tile map
// 32 x 28 tile RAM shared between the CPU and the pixel fetch,
// with the character rule applied to the fetched code
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module tile_vram (
   input  wire logic              clk_48m,
   input  wire logic              reset,
   input  wire logic              cen_6m,
   input  wire logic [9:0]        cpu_a,
   input  wire logic [7:0]        cpu_d,
   input  wire logic              vram_wr_n,
   input  wire logic              vram_rd_n,
   input  wire logic              vram_busy_n,
   input  wire video_pkg::h_cnt_t h_cnt,
   input  wire video_pkg::v_cnt_t v_cnt,
   output logic [7:0]             vram_db,
   output video_pkg::pix_t        tile_pix,
   output video_pkg::colour_t     tile_colour
);

   import video_pkg::*;

   logic [7:0] tile_map [0:1023];
   logic [7:0] v_row;       // Line within the visible area
   logic [9:0] fetch_addr;
   logic [7:0] code_q;
   logic [1:0] col_q;
   logic [1:0] row_q;

   //--------------------------------------------------------------------
   // CPU side
   //--------------------------------------------------------------------
   always_ff @(posedge clk_48m) begin
      if (!vram_wr_n && vram_busy_n)  // Dropped while the beam is on a visible line
         tile_map[cpu_a] <= cpu_d;
   end

   always_ff @(posedge clk_48m) begin
      if (reset)
         vram_db <= '0;
      else if (!vram_rd_n)
         vram_db <= tile_map[cpu_a];
   end

   //--------------------------------------------------------------------
   // Pixel fetch
   //--------------------------------------------------------------------
   assign v_row      = 8'(v_cnt - 9'(`VID_V_FIRST));
   assign fetch_addr = 10'(v_row[7:3] * `VID_MAP_COLS) + 10'(h_cnt[7:3]);

   // Stage one: tile code and position inside the tile
   always_ff @(posedge clk_48m) begin
      if (cen_6m) begin
         code_q <= tile_map[fetch_addr];
         col_q  <= h_cnt[1:0];
         row_q  <= v_row[1:0];
      end
   end

   // Stage two happens in the palette register
   assign tile_pix    = char_pix(code_q, col_q, row_q);
   assign tile_colour = code_q[7:4];    // Upper nibble of the code picks the colour

endmodule

`default_nettype wire

// ==== src/obj_engine.sv ====
//--------------------------------------------------------------------
// Sprite engine
// DMA loaded object RAM, per-line object scan in hblank and a
// double line buffer read and cleared at display time
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module obj_engine (
   input  wire logic              clk_48m,
   input  wire logic              reset,
   input  wire logic              cen_6m,
   input  wire video_pkg::h_cnt_t h_cnt,
   input  wire video_pkg::v_cnt_t v_cnt,
   input  wire logic              hblank_start,
   input  wire logic [5:0]        obj_dma_a,
   input  wire logic [7:0]        obj_dma_d,
   input  wire logic              obj_dma_ce,
   output video_pkg::pix_t        obj_pix,
   output video_pkg::colour_t     obj_colour
);

   import video_pkg::*;

   localparam int IDX_W = $clog2(`VID_OBJ_COUNT);

   logic [7:0]       obj_ram [0:4*`VID_OBJ_COUNT-1];  // Y, code, colour, X
   logic [5:0]       line_buf [0:1][0:255];           // {colour, pix}
   logic             front_sel;
   scan_state_t      state;
   logic [IDX_W-1:0] obj_idx;
   v_cnt_t           target;
   v_cnt_t           line_off;
   logic [2:0]       hit_cnt;
   logic             hit_we;
   logic [IDX_W-1:0] hit_obj [0:`VID_OBJ_PER_LINE-1];
   logic [1:0]       hit_row [0:`VID_OBJ_PER_LINE-1];
   logic [1:0]       draw_slot;
   logic [2:0]       draw_col;
   logic [IDX_W-1:0] d_obj;
   logic [7:0]       d_attr;
   logic [8:0]       d_x;
   pix_t             d_pix;
   logic             draw_we;
   logic [5:0]       front_q;

   always_ff @(posedge clk_48m) begin
      if (obj_dma_ce)
         obj_ram[obj_dma_a] <= obj_dma_d;
   end

   //--------------------------------------------------------------------
   // Scan and draw
   //--------------------------------------------------------------------
   assign line_off = target - v_cnt_t'(obj_ram[{obj_idx, 2'd0}]);
   assign hit_we   = (state == SCAN_COMPARE) && (line_off < 9'd8) &&
                     (hit_cnt < 3'(`VID_OBJ_PER_LINE));

   assign d_obj   = hit_obj[draw_slot];
   assign d_attr  = obj_ram[{d_obj, 2'd2}];
   assign d_x     = {1'b0, obj_ram[{d_obj, 2'd3}]} + 9'(draw_col);
   assign d_pix   = char_pix(obj_ram[{d_obj, 2'd1}], draw_col[1:0], hit_row[draw_slot]);
   assign draw_we = (state == SCAN_DRAW) && (d_pix != 2'd0) && !d_x[8];  // No wrap past 255

   always_ff @(posedge clk_48m) begin
      if (hit_we) begin
         hit_obj[hit_cnt[1:0]] <= obj_idx;
         hit_row[hit_cnt[1:0]] <= line_off[1:0];
      end
   end

   always_ff @(posedge clk_48m) begin
      if (reset) begin
         state     <= SCAN_IDLE;
         front_sel <= 1'b0;
         obj_idx   <= '0;
         target    <= '0;
         hit_cnt   <= '0;
         draw_slot <= '0;
         draw_col  <= '0;
      end else begin
         case (state)
            SCAN_IDLE: begin
               if (cen_6m && hblank_start) begin
                  front_sel <= !front_sel;
                  // Back buffer becomes front at the next swap, two lines on
                  target    <= v_cnt + 9'd2;
                  obj_idx   <= '0;
                  hit_cnt   <= '0;
                  state     <= SCAN_COMPARE;
               end
            end
            SCAN_COMPARE: begin
               if (hit_we)
                  hit_cnt <= hit_cnt + 3'd1;
               obj_idx <= obj_idx + 1'b1;
               if (obj_idx == IDX_W'(`VID_OBJ_COUNT - 1)) begin
                  draw_col <= '0;
                  if (hit_cnt == 3'd0 && !hit_we)
                     state <= SCAN_IDLE;
                  else begin
                     // Start at the last hit so lower numbers land on top
                     draw_slot <= hit_we ? hit_cnt[1:0] : 2'(hit_cnt - 3'd1);
                     state     <= SCAN_DRAW;
                  end
               end
            end
            SCAN_DRAW: begin
               draw_col <= draw_col + 3'd1;
               if (draw_col == 3'd7) begin
                  if (draw_slot == 2'd0)
                     state <= SCAN_IDLE;
                  else
                     draw_slot <= draw_slot - 2'd1;
               end
            end
            default: state <= SCAN_IDLE;
         endcase
      end
   end

   //--------------------------------------------------------------------
   // Line buffers
   //--------------------------------------------------------------------
   always_ff @(posedge clk_48m) begin
      if (cen_6m && (h_cnt < 9'(`VID_H_VISIBLE))) begin
         front_q <= line_buf[front_sel][h_cnt[7:0]];
         line_buf[front_sel][h_cnt[7:0]] <= '0;    // Ready for the next draw
      end
      if (draw_we)
         line_buf[!front_sel][d_x[7:0]] <= {d_attr[3:0], d_pix};
   end

   assign obj_pix    = front_q[1:0];
   assign obj_colour = front_q[5:2];

endmodule

`default_nettype wire

// ==== src/col_pal.sv ====
//--------------------------------------------------------------------
// Colour stage
// Sprite over tile priority, two bank palette RAM and the
// registered, blanked RGB output
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module col_pal (
   input  wire logic                clk_48m,
   input  wire logic                reset,
   input  wire logic                cen_6m,
   input  wire logic                blank,
   input  wire logic                pal_sel,
   input  wire logic [7:0]          cpu_a,
   input  wire logic [7:0]          cpu_d,
   input  wire logic                pal_wr_n,
   input  wire video_pkg::pix_t     tile_pix,
   input  wire video_pkg::colour_t  tile_colour,
   input  wire video_pkg::pix_t     obj_pix,
   input  wire video_pkg::colour_t  obj_colour,
   output video_pkg::rgb_t          rgb
);

   import video_pkg::*;

   rgb_t       pal_ram [0:255];
   logic       blank_dly [`VID_PIX_LATENCY-1];  // One entry per stage before the RGB register
   pal_index_t pal_index;

   always_ff @(posedge clk_48m) begin
      if (!pal_wr_n)
         pal_ram[cpu_a] <= cpu_d;
   end

   // Any opaque sprite pixel wins, upper half of each bank
   assign pal_index = (obj_pix != 2'd0) ? {1'b1, obj_colour, obj_pix}
                                        : {1'b0, tile_colour, tile_pix};

   always_ff @(posedge clk_48m) begin
      if (reset) begin
         rgb <= '0;
         for (int i = 0; i < `VID_PIX_LATENCY - 1; i++)
            blank_dly[i] <= 1'b1;
      end else if (cen_6m) begin
         blank_dly[0] <= blank;
         for (int i = 1; i < `VID_PIX_LATENCY - 1; i++)
            blank_dly[i] <= blank_dly[i-1];
         if (blank_dly[`VID_PIX_LATENCY-2])
            rgb <= '0;
         else
            rgb <= pal_ram[{pal_sel, pal_index}];   // pal_sel picks the bank
      end
   end

endmodule

`default_nettype wire

// ==== src/mario_video.sv ====
//--------------------------------------------------------------------
// Arcade video subsystem top level
// Timing, background tiles, sprites and colour palette
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mario_video (
   input  wire logic          clk_48m,
   input  wire logic          reset,
   input  wire logic          cen_6m,
   input  wire logic [9:0]    cpu_a,
   input  wire logic [7:0]    cpu_d,
   input  wire logic          vram_wr_n,
   input  wire logic          vram_rd_n,
   input  wire logic          pal_wr_n,
   input  wire logic          pal_sel,
   input  wire logic [5:0]    obj_dma_a,
   input  wire logic [7:0]    obj_dma_d,
   input  wire logic          obj_dma_ce,
   output logic [7:0]         vram_db,
   output logic               vram_busy_n,
   output video_pkg::h_cnt_t  h_cnt,
   output video_pkg::v_cnt_t  v_cnt,
   output logic               blank,
   output logic               hblank_start,
   output video_pkg::rgb_t    rgb,
   output logic [2:0]         red,
   output logic [2:0]         green,
   output logic [1:0]         blue
);

   import video_pkg::*;

   pix_t    tile_pix;
   colour_t tile_colour;
   pix_t    obj_pix;
   colour_t obj_colour;

   video_timing timing_i (
      .clk_48m(clk_48m), .reset(reset), .cen_6m(cen_6m),
      .h_cnt(h_cnt), .v_cnt(v_cnt), .blank(blank),
      .hblank_start(hblank_start), .vram_busy_n(vram_busy_n)
   );

   tile_vram tile_i (
      .clk_48m(clk_48m), .reset(reset), .cen_6m(cen_6m),
      .cpu_a(cpu_a), .cpu_d(cpu_d),
      .vram_wr_n(vram_wr_n), .vram_rd_n(vram_rd_n), .vram_busy_n(vram_busy_n),
      .h_cnt(h_cnt), .v_cnt(v_cnt),
      .vram_db(vram_db), .tile_pix(tile_pix), .tile_colour(tile_colour)
   );

   obj_engine obj_i (
      .clk_48m(clk_48m), .reset(reset), .cen_6m(cen_6m),
      .h_cnt(h_cnt), .v_cnt(v_cnt), .hblank_start(hblank_start),
      .obj_dma_a(obj_dma_a), .obj_dma_d(obj_dma_d), .obj_dma_ce(obj_dma_ce),
      .obj_pix(obj_pix), .obj_colour(obj_colour)
   );

   // Palette writes use the low byte of the CPU address
   col_pal col_i (
      .clk_48m(clk_48m), .reset(reset), .cen_6m(cen_6m),
      .blank(blank), .pal_sel(pal_sel),
      .cpu_a(cpu_a[7:0]), .cpu_d(cpu_d), .pal_wr_n(pal_wr_n),
      .tile_pix(tile_pix), .tile_colour(tile_colour),
      .obj_pix(obj_pix), .obj_colour(obj_colour),
      .rgb(rgb)
   );

   assign red   = rgb[7:5];
   assign green = rgb[4:2];
   assign blue  = rgb[1:0];

endmodule

`default_nettype wire

// ==== test/mario_video_asserts.sv ====
//--------------------------------------------------------------------
// Video subsystem assertions
// Counter range, VRAM busy on visible lines and blanked RGB
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module mario_video_asserts (
   input wire logic              clk_48m,
   input wire logic              reset,
   input wire logic              cen_6m,
   input wire video_pkg::h_cnt_t h_cnt,
   input wire video_pkg::v_cnt_t v_cnt,
   input wire logic              blank,
   input wire logic              vram_busy_n,
   input wire video_pkg::rgb_t   rgb
);

   h_range_a : assert property (@(posedge clk_48m) disable iff (reset)
      h_cnt < 9'(`VID_H_TOTAL))
      else $error("h_cnt ran past the line total");

   busy_a : assert property (@(posedge clk_48m) disable iff (reset)
      (v_cnt >= 9'(`VID_V_FIRST) && v_cnt <= 9'(`VID_V_LAST)) |-> !vram_busy_n)
      else $error("vram_busy_n high on a visible line");

   // Blanked pixel reaches the RGB register on the following strobe
   blank_rgb_a : assert property (@(posedge clk_48m) disable iff (reset)
      (cen_6m && blank) |=> cen_6m[->1] ##1 (rgb == 8'h00))
      else $error("rgb not zero for a blanked pixel");

endmodule

bind mario_video mario_video_asserts asserts_i (
   .clk_48m(clk_48m), .reset(reset), .cen_6m(cen_6m),
   .h_cnt(h_cnt), .v_cnt(v_cnt), .blank(blank),
   .vram_busy_n(vram_busy_n), .rgb(rgb)
);

`default_nettype wire

// ==== test/mario_video_tb.sv ====
//--------------------------------------------------------------------
// Arcade video subsystem testbench
// Directed tests of timing, tile map, sprites and palette, checked
// against a model of the raster built from the video rules
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "video_config.svh"

module mario_video_tb;

   // 8 ns clock, 8 clocks per pixel
   localparam longint FRAME_NS = 64 * `VID_H_TOTAL * `VID_V_TOTAL;
   // Tests end in the fourth frame, just short of 3.5 frames
   localparam longint WATCHDOG_NS = 4 * FRAME_NS + FRAME_NS / 2;
   localparam int SPR_LINE = 120;

   logic       clk_48m;
   logic       reset;
   logic       cen_6m;
   logic [9:0] cpu_a;
   logic [7:0] cpu_d;
   logic       vram_wr_n;
   logic       vram_rd_n;
   logic       pal_wr_n;
   logic       pal_sel;
   logic [5:0] obj_dma_a;
   logic [7:0] obj_dma_d;
   logic       obj_dma_ce;
   logic [7:0] vram_db;
   logic       vram_busy_n;
   logic [8:0] h_cnt;
   logic [8:0] v_cnt;
   logic       blank;
   logic       hblank_start;
   logic [7:0] rgb;
   logic [2:0] red;
   logic [2:0] green;
   logic [1:0] blue;

   logic [2:0]  div_cnt;
   logic [31:0] rng_state;
   logic [7:0]  tmap [0:1023];  // Reference copies of the DUT memories
   logic [7:0]  oram [0:63];
   logic [7:0]  pal [0:255];

   mario_video dut_i (.*);

   initial clk_48m = 1'b0;
   always #4 clk_48m = !clk_48m;

   always @(negedge clk_48m) begin
      div_cnt <= div_cnt + 3'd1;
      cen_6m  <= (div_cnt == 3'd6);  // One clock in eight
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

   //--------------------------------------------------------------------
   // Helpers, each starts and ends on a falling edge
   //--------------------------------------------------------------------
   function automatic logic [31:0] rand32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Field (c xor r) mod 4 of the character code
   function automatic int shape_pix(input logic [7:0] code, input int c, input int r);
      return (code >> (2 * ((c ^ r) & 3))) & 3;
   endfunction

   function automatic logic [7:0] expect_rgb(input int h, input int v);
      int         row;
      int         idx;
      int         hits;
      int         y;
      int         c;
      int         p;
      int         o;
      logic [7:0] code;
      logic       found;
      if (h >= `VID_H_VISIBLE || v < `VID_V_FIRST || v > `VID_V_LAST)
         return 8'h00;
      row  = v - `VID_V_FIRST;
      code = tmap[(row / 8) * `VID_MAP_COLS + h / 8];
      idx  = 4 * code[7:4] + shape_pix(code, h, row);
      hits  = 0;
      found = 1'b0;
      for (o = 0; o < `VID_OBJ_COUNT; o++) begin
         y = v - int'(oram[4 * o]);
         if (y >= 0 && y < 8 && hits < `VID_OBJ_PER_LINE) begin
            hits++;
            c = h - int'(oram[4 * o + 3]);
            p = shape_pix(oram[4 * o + 1], c, y);
            if (!found && c >= 0 && c < 8 && p != 0) begin  // Lowest opaque object wins
               idx   = 64 + 4 * oram[4 * o + 2][3:0] + p;
               found = 1'b1;
            end
         end
      end
      return pal[pal_sel ? idx + 128 : idx];
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic next_strobe();
      @(posedge clk_48m);
      while (!cen_6m)
         @(posedge clk_48m);
      @(negedge clk_48m);
   endtask

   task automatic wait_for(input int v, input int h);
      while (v_cnt != v || h_cnt != h)
         next_strobe();
   endtask

   task automatic vram_write(input logic [9:0] a, input logic [7:0] d, input logic accepted);
      if (accepted)
         tmap[a] = d;   // Dropped on visible lines
      cpu_a     = a;
      cpu_d     = d;
      vram_wr_n = 1'b0;
      @(negedge clk_48m);
      vram_wr_n = 1'b1;
   endtask

   task automatic vram_read_check(input logic [9:0] a);
      cpu_a     = a;
      vram_rd_n = 1'b0;
      @(negedge clk_48m);
      vram_rd_n = 1'b1;
      check_eq(vram_db, tmap[a], $sformatf("vram_db at %0h", a));
   endtask

   task automatic pal_write(input logic [7:0] a, input logic [7:0] d);
      pal[a]   = d;
      cpu_a    = {2'b00, a};
      cpu_d    = d;
      pal_wr_n = 1'b0;
      @(negedge clk_48m);
      pal_wr_n = 1'b1;
   endtask

   task automatic dma_write(input int a, input logic [7:0] d);
      oram[a]    = d;
      obj_dma_a  = 6'(a);
      obj_dma_d  = d;
      obj_dma_ce = 1'b1;
      @(negedge clk_48m);
      obj_dma_ce = 1'b0;
   endtask

   task automatic load_object(input int n, input int y, input logic [7:0] code, input int x);
      dma_write(4 * n, 8'(y));
      dma_write(4 * n + 1, code);
      dma_write(4 * n + 2, 8'(rand32()));  // Colour in the low nibble
      dma_write(4 * n + 3, 8'(x));
   endtask

   // Pixel h of line v is on rgb once h_cnt reaches h + 2
   task automatic check_line(input int v);
      int         h;
      logic [7:0] want;
      wait_for(v, 2);
      for (h = 0; h < `VID_H_VISIBLE + 4; h++) begin
         want = expect_rgb(h, v);
         check_eq(rgb, want, $sformatf("rgb at h %0d v %0d", h, v));
         check_eq({red, green, blue}, want, $sformatf("colour slices at h %0d v %0d", h, v));
         next_strobe();
      end
   endtask

   //--------------------------------------------------------------------
   // Tests
   //--------------------------------------------------------------------
   task automatic test_reset();
      int i;
      check_eq(rgb, 0, "rgb after reset");
      check_eq({v_cnt, h_cnt, vram_busy_n}, 1, "counters after reset");
      for (i = 1; i <= 8; i++) begin
         next_strobe();
         check_eq(h_cnt, i, "h_cnt step");
      end
      for (i = 0; i < `VID_OBJ_COUNT; i++)
         load_object(i, 248, 8'h00, 0);   // Parked below the screen before the first scan
      wait_for(0, `VID_H_VISIBLE - 1);
      check_eq(hblank_start, 0, "hblank_start before hblank");
      next_strobe();
      check_eq(hblank_start, 1, "hblank_start at h 256");
      next_strobe();
      check_eq(hblank_start, 0, "hblank_start one strobe wide");
      wait_for(0, `VID_H_TOTAL - 1);
      next_strobe();
      check_eq({v_cnt, h_cnt}, {9'd1, 9'd0}, "h wrap");
      wait_for(`VID_V_FIRST - 1, `VID_H_TOTAL - 1);
      check_eq(vram_busy_n, 1, "busy_n before first visible line");
      next_strobe();
      check_eq({v_cnt, h_cnt, vram_busy_n, blank}, {9'd16, 9'd0, 2'b00}, "first visible pixel");
      wait_for(`VID_V_TOTAL - 1, `VID_H_TOTAL - 1);
      next_strobe();
      check_eq({v_cnt, h_cnt}, 0, "v wrap");
   endtask

   task automatic test_vram();
      int         i;
      logic [9:0] a;
      logic [7:0] old;
      // Line 0 of the frame, all of it vertical blank
      for (i = 0; i < 1024; i++)
         vram_write(10'(i), 8'(rand32()), 1'b1);
      for (i = 0; i < 32; i++)
         vram_read_check(10'(rand32()));
      wait_for(20, 0);
      a   = 10'(rand32());
      old = tmap[a];
      check_eq(vram_busy_n, 0, "busy_n on visible line");
      vram_write(a, ~old, 1'b0);
      wait_for(`VID_V_LAST + 1, 0);
      vram_read_check(a);
      check_eq(vram_db, old, "write while busy kept old byte");
   endtask

   task automatic test_tiles();
      int i;
      for (i = 0; i < 256; i++)
         pal_write(8'(i), 8'(rand32()));
      check_line(35);
   endtask

   task automatic test_sprites();
      load_object(0, SPR_LINE - 3, 8'h1b, 40);   // Top field transparent
      load_object(1, SPR_LINE - 5, 8'hff, 44);   // Partly under object 0
      load_object(2, SPR_LINE, 8'he4, 100);
      load_object(3, SPR_LINE - 7, 8'h55, 140);
      load_object(4, SPR_LINE - 1, 8'hff, 180);  // Fifth hit on the line
      check_line(SPR_LINE);
   endtask

   task automatic test_palette();
      int i;
      pal_sel = 1'b1;
      check_line(SPR_LINE + 4);
      wait_for(`VID_V_LAST + 1, 0);
      for (i = 0; i < 256; i++)
         pal_write(8'(i), 8'(rand32()));
      pal_sel = 1'b0;
      check_line(SPR_LINE + 4);
   endtask

   initial begin
      rng_state  = 32'hcc8e7e92;
      div_cnt    = 3'd0;
      reset      = 1'b1;
      cen_6m     = 1'b0;
      cpu_a      = '0;
      cpu_d      = '0;
      vram_wr_n  = 1'b1;
      vram_rd_n  = 1'b1;
      pal_wr_n   = 1'b1;
      pal_sel    = 1'b0;
      obj_dma_a  = '0;
      obj_dma_d  = '0;
      obj_dma_ce = 1'b0;
      repeat (4) @(negedge clk_48m);
      reset = 1'b0;
      test_reset();
      test_vram();
      test_tiles();
      test_sprites();
      test_palette();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/video_pkg.sv
src/video_timing.sv
src/tile_vram.sv
src/obj_engine.sv
src/col_pal.sv
src/mario_video.sv
test/mario_video_asserts.sv
test/mario_video_tb.sv
